// File: Bender.yml
package:
  name: snakeGame

sources:
  - include_dirs:
      - .
    files:
      - snakePkg.sv
      - snakeBody.sv
      - headSteering.sv
      - appleKeeper.sv
      - collisionCheck.sv
      - scoreDisplay.sv
      - drawSequencer.sv
      - snakeGame.sv
  - target: test
    include_dirs:
      - .
    files:
      - snakeGame_tb.sv

// File: appleKeeper.sv
/*
 * Apple keeper.
 * Steps through the fixed apple position table when an apple is
 * eaten and reports when the head square covers the apple.
 */
`timescale 1ns/100ps
`include "snakeGame_settings.svh"

module appleKeeper import snakePkg::*; (
    input  logic    Clock,
    input  logic    reset,
    input  logic    appleAdvance,
    input  xCoord_t headX,
    input  yCoord_t headY,
    output xCoord_t appleX,
    output yCoord_t appleY,
    output logic    appleOverlap
);

    localparam int idxBits = $clog2(`APPLE_COUNT);

    localparam xCoord_t tableX [`APPLE_COUNT] = `APPLE_TABLE_X;
    localparam yCoord_t tableY [`APPLE_COUNT] = `APPLE_TABLE_Y;

    logic [idxBits-1:0] appleIndex;

    // cyclic table pointer
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            appleIndex <= '0;
        end
        else if (appleAdvance)
        begin
            if (appleIndex == idxBits'(`APPLE_COUNT - 1))
                appleIndex <= '0;
            else
                appleIndex <= appleIndex + 1'b1;
        end
    end

    assign appleX = tableX[appleIndex];
    assign appleY = tableY[appleIndex];

    // apple square has the same side as a segment
    assign appleOverlap = squaresOverlap(headX, headY, appleX, appleY, `SEG_SIZE);

endmodule

// File: collisionCheck.sv
/*
 * Collision check.
 * Flags when the head square overlaps any body segment far
 * enough back to be reachable by the head.
 */
`timescale 1ns/100ps
`include "snakeGame_settings.svh"

module collisionCheck import snakePkg::*; (
    input  xCoord_t headX,
    input  yCoord_t headY,
    input  xCoord_t segmentX [`SNAKE_LENGTH],
    input  yCoord_t segmentY [`SNAKE_LENGTH],
    output logic    hit
);

    // segments close to the head always touch it, so they are skipped
    always_comb
    begin
        hit = 1'b0;
        for (int k = `MIN_HIT_SEGMENT; k < `SNAKE_LENGTH; k++)
        begin
            if (squaresOverlap(headX, headY, segmentX[k], segmentY[k], `SEG_SIZE))
            begin
                hit = 1'b1;
            end
        end
    end

endmodule

// File: drawSequencer.sv
/*
 * Draw sequencer.
 * Game FSM with the tick divider. Draws the apple and the snake,
 * erases the snake, checks for collision and moves the snake,
 * one pixel per cycle.
 */
`timescale 1ns/100ps
`include "snakeGame_settings.svh"

module drawSequencer import snakePkg::*; #(
    parameter int tickBits = `TICK_BITS
) (
    input  logic    Clock,
    input  logic    reset,
    input  logic    start,
    input  logic    moving,
    input  logic    hit,
    input  logic    appleOverlap,
    input  colour_t snakeColour,
    input  xCoord_t segmentX [`SNAKE_LENGTH],
    input  yCoord_t segmentY [`SNAKE_LENGTH],
    input  xCoord_t appleX,
    input  yCoord_t appleY,
    output logic    plot,
    output logic    step,
    output logic    shift,
    output logic    appleAdvance,
    output logic    gameOver,
    output xCoord_t pixelX,
    output yCoord_t pixelY,
    output colour_t pixelColour
);

    localparam int cntBits = $clog2(`SEG_SIZE);
    localparam int segBits = $clog2(`SNAKE_LENGTH);

    typedef enum logic [3:0] {
        sIdle, sApple, sDraw, sWait, sErase, sCheck, sStep, sShift, sEat, sOver
    } seqState_t;

    seqState_t state;
    seqState_t nextState;

    logic [tickBits-1:0] tickCount;
    logic                tick;
    logic [cntBits-1:0]  col;
    logic [cntBits-1:0]  row;
    logic [segBits-1:0]  segIndex;
    logic                painting;
    logic                lastCol;
    logic                lastRow;
    logic                lastSeg;
    logic                squareDone;
    xCoord_t             originX;
    yCoord_t             originY;

    // free running game pace
    always_ff @(posedge Clock)
    begin
        if (reset)
            tickCount <= '0;
        else
            tickCount <= tickCount + 1'b1;
    end

    assign tick = (tickCount == '0);

    assign painting = (state == sApple) || (state == sDraw) || (state == sErase);
    assign lastCol = (col == cntBits'(`SEG_SIZE - 1));
    assign lastRow = (row == cntBits'(`SEG_SIZE - 1));
    assign lastSeg = (segIndex == segBits'(`SNAKE_LENGTH - 1));
    assign squareDone = lastCol && lastRow;

    always_comb
    begin
        nextState = state;
        case (state)
            // first frame waits for start
            sIdle:
                if (start && tick)
                    nextState = sApple;
            sApple:
                if (squareDone)
                    nextState = sDraw;
            sDraw:
                if (squareDone && lastSeg)
                    nextState = sWait;
            // no rounds before the first key press
            sWait:
                if (moving && tick)
                    nextState = sErase;
            sErase:
                if (squareDone && lastSeg)
                    nextState = sCheck;
            sCheck:
                nextState = hit ? sOver : sStep;
            sStep:
                nextState = sShift;
            sShift:
                nextState = sEat;
            // new apple drawn before the body
            sEat:
                nextState = appleOverlap ? sApple : sDraw;
            sOver:
                nextState = sOver;
            default:
                nextState = sIdle;
        endcase
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            state <= sIdle;
            gameOver <= 1'b0;
        end
        else
        begin
            state <= nextState;
            if (state == sCheck && hit)
                gameOver <= 1'b1;
        end
    end

    // x fastest, then rows, then segments
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            col <= '0;
            row <= '0;
            segIndex <= '0;
        end
        else if (painting)
        begin
            if (!lastCol)
            begin
                col <= col + 1'b1;
            end
            else
            begin
                col <= '0;
                if (!lastRow)
                begin
                    row <= row + 1'b1;
                end
                else
                begin
                    row <= '0;
                    // apple is a single square
                    if (state == sApple || lastSeg)
                        segIndex <= '0;
                    else
                        segIndex <= segIndex + 1'b1;
                end
            end
        end
    end

    // square origin from apple or selected segment
    assign originX = (state == sApple) ? appleX : segmentX[segIndex];
    assign originY = (state == sApple) ? appleY : segmentY[segIndex];
    assign pixelX = originX + xCoord_t'(col);
    assign pixelY = originY + yCoord_t'(row);

    always_comb
    begin
        case (state)
            sApple:  pixelColour = `APPLE_COLOUR;
            sErase:  pixelColour = `ERASE_COLOUR;
            default: pixelColour = snakeColour;
        endcase
    end

    assign plot = painting;
    assign step = (state == sStep);
    assign shift = (state == sShift);
    assign appleAdvance = (state == sEat) && appleOverlap;

    // nothing reaches the screen once the game has ended
    plotOnlyWhilePainting: assert property (@(posedge Clock) disable iff (reset)
        plot |-> (state inside {sApple, sDraw, sErase}) && !gameOver);

    // the snake is frozen after game over
    noMoveAfterGameOver: assert property (@(posedge Clock) disable iff (reset)
        gameOver |-> !step && !shift);

endmodule

// File: headSteering.sv
/*
 * Head steering.
 * Latches a direction from the active-low keys and moves the
 * head one pixel per step in that direction.
 */
`timescale 1ns/100ps
`include "snakeGame_settings.svh"

module headSteering import snakePkg::*; (
    input  logic       Clock,
    input  logic       reset,
    input  logic       step,
    input  logic [3:0] keys,
    output xCoord_t    headX,
    output yCoord_t    headY,
    output logic       moving
);

    direction_t direction;
    direction_t keyDirection;
    logic       keyPressed;

    // lowest key index wins
    always_comb
    begin
        if (!keys[0])
            keyDirection = dirRight;
        else if (!keys[1])
            keyDirection = dirDown;
        else if (!keys[2])
            keyDirection = dirUp;
        else if (!keys[3])
            keyDirection = dirLeft;
        else
            keyDirection = dirNone;
    end

    assign keyPressed = (keyDirection != dirNone);

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            direction <= dirNone;
            moving <= 1'b0;
            headX <= `START_X;
            headY <= `START_Y;
        end
        else
        begin
            // direction holds after release
            if (keyPressed)
            begin
                direction <= keyDirection;
                moving <= 1'b1;
            end
            // coordinates wrap at their width
            if (step)
            begin
                case (direction)
                    dirRight: headX <= headX + 1'b1;
                    dirLeft:  headX <= headX - 1'b1;
                    dirDown:  headY <= headY + 1'b1;
                    dirUp:    headY <= headY - 1'b1;
                    default:  headX <= headX;
                endcase
            end
        end
    end

    // once moving, a real direction is always held
    movingHasDirection: assert property (@(posedge Clock) disable iff (reset)
        moving |-> (direction != dirNone));

endmodule

// File: scoreDisplay.sv
/*
 * Score display.
 * Counts eaten apples modulo 16 and shows the count as one
 * active-low hexadecimal seven-segment digit.
 */
`timescale 1ns/100ps

module scoreDisplay (
    input  logic       Clock,
    input  logic       reset,
    input  logic       appleAdvance,
    output logic [6:0] scoreSegments
);

    logic [3:0] score;

    always_ff @(posedge Clock)
    begin
        if (reset)
            score <= 4'd0;
        else if (appleAdvance)
            score <= score + 4'd1;
    end

    // bit 0 top, clockwise, bit 6 middle
    always_comb
    begin
        case (score)
            4'h0: scoreSegments = 7'b1000000;
            4'h1: scoreSegments = 7'b1111001;
            4'h2: scoreSegments = 7'b0100100;
            4'h3: scoreSegments = 7'b0110000;
            4'h4: scoreSegments = 7'b0011001;
            4'h5: scoreSegments = 7'b0010010;
            4'h6: scoreSegments = 7'b0000010;
            4'h7: scoreSegments = 7'b1111000;
            4'h8: scoreSegments = 7'b0000000;
            4'h9: scoreSegments = 7'b0010000;
            4'hA: scoreSegments = 7'b0001000;
            4'hB: scoreSegments = 7'b0000011;
            4'hC: scoreSegments = 7'b1000110;
            4'hD: scoreSegments = 7'b0100001;
            4'hE: scoreSegments = 7'b0000110;
            default: scoreSegments = 7'b0001110;
        endcase
    end

    // score only moves on an eaten apple
    scoreHoldsWithoutApple: assert property (@(posedge Clock) disable iff (reset)
        !appleAdvance |=> $stable(score));

endmodule

// File: snakeBody.sv
/*
 * Snake body history.
 * Shift register of past head positions for one axis. Every
 * SEG_SIZE-th entry is the origin of one body segment.
 */
`timescale 1ns/100ps
`include "snakeGame_settings.svh"

module snakeBody import snakePkg::*; #(
    parameter type coordType = xCoord_t,
    parameter int startBase = 0,
    parameter int startStride = 0
) (
    input  logic     Clock,
    input  logic     reset,
    input  logic     shift,
    input  coordType head,
    output coordType segments [`SNAKE_LENGTH]
);

    localparam int histDepth = `SNAKE_LENGTH * `SEG_SIZE;

    // entry 0 is the newest head position
    coordType history [histDepth];

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            // each block of SEG_SIZE entries holds its segment's start
            for (int i = 0; i < histDepth; i++)
            begin
                history[i] <= coordType'(startBase + (i / `SEG_SIZE) * startStride);
            end
        end
        else if (shift)
        begin
            history[0] <= head;
            // everything ages by one place
            for (int i = 1; i < histDepth; i++)
            begin
                history[i] <= history[i - 1];
            end
        end
    end

    // segment k trails the head by k squares
    always_comb
    begin
        for (int k = 0; k < `SNAKE_LENGTH; k++)
        begin
            segments[k] = history[k * `SEG_SIZE];
        end
    end

endmodule

// File: snakeGame.f
+incdir+.
snakePkg.sv
snakeBody.sv
headSteering.sv
appleKeeper.sv
collisionCheck.sv
scoreDisplay.sv
drawSequencer.sv
snakeGame.sv
snakeGame_tb.sv

// File: snakeGame.sv
/*
 * Snake game top level.
 * Connects steering, body history, apple, collision, score and
 * the draw sequencer into one pixel-plot stream.
 */
`timescale 1ns/100ps
`include "snakeGame_settings.svh"

module snakeGame import snakePkg::*; #(
    parameter int tickBits = `TICK_BITS
) (
    input  logic       Clock,
    input  logic       reset,
    input  logic       start,
    input  logic [3:0] keys,
    input  colour_t    snakeColour,
    output logic       plot,
    output xCoord_t    pixelX,
    output yCoord_t    pixelY,
    output colour_t    pixelColour,
    output logic       gameOver,
    output logic [6:0] scoreSegments
);

    logic    step;
    logic    shift;
    logic    moving;
    logic    hit;
    logic    appleAdvance;
    logic    appleOverlap;
    xCoord_t headX;
    yCoord_t headY;
    xCoord_t appleX;
    yCoord_t appleY;
    xCoord_t segmentX [`SNAKE_LENGTH];
    yCoord_t segmentY [`SNAKE_LENGTH];

    headSteering steering (
        .Clock(Clock), .reset(reset), .step(step), .keys(keys),
        .headX(headX), .headY(headY), .moving(moving)
    );

    // start column is a vertical line below the head
    snakeBody #(.coordType(xCoord_t), .startBase(`START_X), .startStride(0)) bodyX (
        .Clock(Clock), .reset(reset), .shift(shift), .head(headX), .segments(segmentX)
    );

    snakeBody #(.coordType(yCoord_t), .startBase(`START_Y), .startStride(`SEG_SIZE)) bodyY (
        .Clock(Clock), .reset(reset), .shift(shift), .head(headY), .segments(segmentY)
    );

    collisionCheck collision (
        .headX(headX), .headY(headY), .segmentX(segmentX), .segmentY(segmentY), .hit(hit)
    );

    appleKeeper apple (
        .Clock(Clock), .reset(reset), .appleAdvance(appleAdvance),
        .headX(headX), .headY(headY),
        .appleX(appleX), .appleY(appleY), .appleOverlap(appleOverlap)
    );

    scoreDisplay score (
        .Clock(Clock), .reset(reset), .appleAdvance(appleAdvance),
        .scoreSegments(scoreSegments)
    );

    drawSequencer #(.tickBits(tickBits)) sequencer (
        .Clock(Clock), .reset(reset), .start(start), .moving(moving), .hit(hit),
        .appleOverlap(appleOverlap), .snakeColour(snakeColour),
        .segmentX(segmentX), .segmentY(segmentY), .appleX(appleX), .appleY(appleY),
        .plot(plot), .step(step), .shift(shift), .appleAdvance(appleAdvance),
        .gameOver(gameOver), .pixelX(pixelX), .pixelY(pixelY), .pixelColour(pixelColour)
    );

endmodule

// File: snakeGame_settings.svh
/*
 * Snake game constants.
 * Screen size, segment geometry, start positions, apple table,
 * colours and the width of the game tick divider.
 */
`ifndef SNAKEGAME_SETTINGS_SVH
`define SNAKEGAME_SETTINGS_SVH

// display area in pixels
`define SCREEN_WIDTH 8'd160
`define SCREEN_HEIGHT 7'd120

// square side for snake segments and the apple
`define SEG_SIZE 10
`define SNAKE_LENGTH 6
`define MIN_HIT_SEGMENT 3

// head start, body hangs below it
`define START_X 8'd80
`define START_Y 7'd60

// apple positions visited in order, wrapping
`define APPLE_COUNT 7
`define APPLE_TABLE_X '{8'd30, 8'd10, 8'd70, 8'd60, 8'd20, 8'd50, 8'd80}
`define APPLE_TABLE_Y '{7'd30, 7'd20, 7'd90, 7'd100, 7'd80, 7'd10, 7'd50}

`define APPLE_COLOUR 3'b100
`define ERASE_COLOUR 3'b000

// game pace divider width
`define TICK_BITS 20

`endif

// File: snakeGame_tb.sv
/*
 * Snake game testbench.
 * Applies a table of key phases to the game and checks every plotted
 * pixel, the score digit and gameOver against a reference model.
 */
`timescale 1ns/100ps
`include "snakeGame_settings.svh"

module snakeGame_tb import snakePkg::*; ();

    // short tick so a round is mostly pixels
    localparam int gameTickBits = 4;
    localparam int sqPixels = `SEG_SIZE * `SEG_SIZE;
    localparam int histDepth = `SNAKE_LENGTH * `SEG_SIZE;
    localparam colour_t bodyColour = 3'b010;
    localparam int phaseCount = 3;

    localparam xCoord_t appleTableX [`APPLE_COUNT] = `APPLE_TABLE_X;
    localparam yCoord_t appleTableY [`APPLE_COUNT] = `APPLE_TABLE_Y;

    // phases: up to the apple row, left onto the apple, reversal into the body
    localparam logic [3:0] phaseKeys [phaseCount] = '{4'b1011, 4'b0111, 4'b1110};
    localparam int phaseRounds [phaseCount] = '{21, 41, 12};
    localparam int phaseScore [phaseCount] = '{0, 1, 1};
    localparam logic phaseOver [phaseCount] = '{1'b0, 1'b0, 1'b1};

    // gfedcba, active high, for 0..F
    localparam logic [6:0] hexGlyph [16] = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D,
        7'h7D, 7'h07, 7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};

    // tick wait, erase, apple and snake, plus control states
    localparam int roundCycles = (1 << gameTickBits) + (2 * `SNAKE_LENGTH + 1) * sqPixels + 8;
    localparam int totalRounds = phaseRounds[0] + phaseRounds[1] + phaseRounds[2];
    localparam int cycleLimit = 2 * (totalRounds + 4) * roundCycles;

    logic       Clock;
    logic       reset;
    logic       start;
    logic [3:0] keys;
    colour_t    snakeColour;
    logic       plot;
    xCoord_t    pixelX;
    yCoord_t    pixelY;
    colour_t    pixelColour;
    logic       gameOver;
    logic [6:0] scoreSegments;

    // reference model
    xCoord_t histX [histDepth];
    yCoord_t histY [histDepth];
    xCoord_t modelHeadX;
    yCoord_t modelHeadY;
    int      modelApple;
    int      modelScore;
    logic    modelOver;
    int      cycleCount = 0;

    snakeGame #(.tickBits(gameTickBits)) UUT (
        .Clock(Clock), .reset(reset), .start(start), .keys(keys),
        .snakeColour(snakeColour), .plot(plot), .pixelX(pixelX), .pixelY(pixelY),
        .pixelColour(pixelColour), .gameOver(gameOver), .scoreSegments(scoreSegments)
    );

    initial Clock = 1'b0;
    always #4 Clock = ~Clock;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // watchdog against a stalled game
    always @(posedge Clock)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit)
            abortRun("Timeout: the game did not finish the phase table in time");
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        assert (got === expected)
        else
            abortRun($sformatf("** Error at %0t: %s is %0d, expected %0d",
                               $time, name, got, expected));
    endtask

    function automatic logic [6:0] digitFor(input int value);
        return ~hexGlyph[value % 16];
    endfunction

    // squares closer than one side on both axes
    function automatic logic touching(input int ax, input int ay, input int bx, input int by);
        int dx;
        int dy;
        dx = (ax > bx) ? ax - bx : bx - ax;
        dy = (ay > by) ? ay - by : by - ay;
        return (dx < `SEG_SIZE) && (dy < `SEG_SIZE);
    endfunction

    task automatic modelReset();
        // vertical line, head on top
        for (int i = 0; i < histDepth; i++)
        begin
            histX[i] = `START_X;
            histY[i] = yCoord_t'(`START_Y + (i / `SEG_SIZE) * `SEG_SIZE);
        end
        modelHeadX = `START_X;
        modelHeadY = `START_Y;
        modelApple = 0;
        modelScore = 0;
        modelOver = 1'b0;
    endtask

    // idle cycles, nothing plotted
    task automatic quietCycles(input int count);
        repeat (count)
        begin
            @(negedge Clock);
            checkValue("plot", plot, 0);
            checkValue("gameOver", gameOver, modelOver);
            checkValue("scoreSegments", scoreSegments, digitFor(modelScore));
        end
    endtask

    // rows from the top, x fastest
    task automatic expectSquare(input xCoord_t originX, input yCoord_t originY,
                                input colour_t colour);
        for (int i = 0; i < sqPixels; i++)
        begin
            do
                @(negedge Clock);
            while (!plot);
            checkValue("pixelX", pixelX, xCoord_t'(originX + i % `SEG_SIZE));
            checkValue("pixelY", pixelY, yCoord_t'(originY + i / `SEG_SIZE));
            checkValue("pixelColour", pixelColour, colour);
        end
    endtask

    // head first, every SEG_SIZE-th history entry
    task automatic expectSnake(input colour_t colour);
        for (int k = 0; k < `SNAKE_LENGTH; k++)
        begin
            expectSquare(histX[k * `SEG_SIZE], histY[k * `SEG_SIZE], colour);
        end
    endtask

    task automatic playRound(input logic [3:0] pressed);
        logic hitNow;
        hitNow = 1'b0;
        expectSnake(`ERASE_COLOUR);
        for (int k = `MIN_HIT_SEGMENT; k < `SNAKE_LENGTH; k++)
        begin
            if (touching(modelHeadX, modelHeadY, histX[k * `SEG_SIZE], histY[k * `SEG_SIZE]))
                hitNow = 1'b1;
        end
        if (hitNow)
        begin
            modelOver = 1'b1;
            // no pixel while the end of game settles
            do
            begin
                @(negedge Clock);
                checkValue("plot", plot, 0);
            end
            while (!gameOver);
        end
        else
        begin
            // lowest pressed key sets the direction
            if (!pressed[0])
                modelHeadX = modelHeadX + 1'b1;
            else if (!pressed[1])
                modelHeadY = modelHeadY + 1'b1;
            else if (!pressed[2])
                modelHeadY = modelHeadY - 1'b1;
            else if (!pressed[3])
                modelHeadX = modelHeadX - 1'b1;
            for (int i = histDepth - 1; i > 0; i--)
            begin
                histX[i] = histX[i - 1];
                histY[i] = histY[i - 1];
            end
            histX[0] = modelHeadX;
            histY[0] = modelHeadY;
            if (touching(modelHeadX, modelHeadY, appleTableX[modelApple],
                         appleTableY[modelApple]))
            begin
                modelApple = (modelApple + 1) % `APPLE_COUNT;
                modelScore = modelScore + 1;
                expectSquare(appleTableX[modelApple], appleTableY[modelApple], `APPLE_COLOUR);
            end
            expectSnake(bodyColour);
        end
    endtask

    initial
    begin
        reset = 1'b1;
        start = 1'b0;
        keys = 4'b1111;
        snakeColour = bodyColour;
        modelReset();
        quietCycles(15);
        @(posedge Clock);
        #1 reset = 1'b0;
        quietCycles(40);
        @(posedge Clock);
        #1 start = 1'b1;
        // first frame, then nothing until a key
        expectSquare(appleTableX[0], appleTableY[0], `APPLE_COLOUR);
        expectSnake(bodyColour);
        quietCycles(3 << gameTickBits);
        for (int p = 0; p < phaseCount; p++)
        begin
            @(posedge Clock);
            #1 keys = phaseKeys[p];
            for (int r = 0; r < phaseRounds[p] && !modelOver; r++)
            begin
                playRound(phaseKeys[p]);
                checkValue("scoreSegments", scoreSegments, digitFor(modelScore));
            end
            checkValue("gameOver", gameOver, phaseOver[p]);
            checkValue("scoreSegments", scoreSegments, digitFor(phaseScore[p]));
        end
        // frozen game ignores keys
        @(posedge Clock);
        #1 keys = 4'b1101;
        quietCycles(2 * roundCycles);
        $display("Regression passed");
        $finish;
    end

endmodule

// File: snakePkg.sv
/*
 * Snake game types.
 * Pixel coordinates, colour, steering direction and the
 * square overlap test shared by the apple and collision logic.
 */
package snakePkg;

    // 160x120 screen
    typedef logic [7:0] xCoord_t;
    typedef logic [6:0] yCoord_t;

    // one bit each of red, green, blue
    typedef logic [2:0] colour_t;

    typedef enum logic [2:0] {dirNone, dirRight, dirDown, dirUp, dirLeft} direction_t;

    // strict overlap of two squares of the same side
    function automatic logic squaresOverlap(
        input xCoord_t ax,
        input yCoord_t ay,
        input xCoord_t bx,
        input yCoord_t by,
        input int size
    );
        logic overlapX;
        logic overlapY;
        // widened so that origin plus size never wraps
        overlapX = (int'(ax) < int'(bx) + size) && (int'(ax) + size > int'(bx));
        overlapY = (int'(ay) < int'(by) + size) && (int'(ay) + size > int'(by));
        return overlapX && overlapY;
    endfunction

endpackage
